// File: udp_echo_params.svh
`ifndef UDP_ECHO_PARAMS_SVH
`define UDP_ECHO_PARAMS_SVH

// Payload stream width and byte enables
`define UDP_DATA_W 64
`define UDP_KEEP_W 8

// Frames sent to this port are echoed, everything else is dropped
`define UDP_ECHO_PORT 16'd1234

// 1024 entry payload FIFO
`define UDP_FIFO_ADDR_W 10

// LED register shows the low byte of the first payload beat
`define UDP_LED_W 8

`endif

// File: udp_echo_pkg.sv
package udp_echo_pkg;

    // Per-frame decision taken when a header is accepted
    typedef enum logic [1:0] {
        FILTER_IDLE = 2'd0,
        FILTER_ECHO = 2'd1,
        FILTER_DROP = 2'd2
    } filter_state_t;

    // Reply header fields that vary per frame
    // Source IP, TTL, DSCP/ECN and checksum are filled in by the stack
    typedef struct packed {
        logic [31:0] dest_ip;
        logic [15:0] source_port;
        logic [15:0] dest_port;
        logic [15:0] length;
    } reply_hdr_t;

endpackage

// File: udp_stream_if.sv
`include "udp_echo_params.svh"

interface udp_stream_if;

    logic [`UDP_DATA_W-1:0] tdata;
    logic [`UDP_KEEP_W-1:0] tkeep;
    logic                   tvalid;
    logic                   tready;
    logic                   tlast;
    logic                   tuser;

    // Producer side of the stream
    modport source (
        output tdata,
        output tkeep,
        output tvalid,
        input  tready,
        output tlast,
        output tuser
    );

    // Consumer side of the stream
    modport sink (
        input  tdata,
        input  tkeep,
        input  tvalid,
        output tready,
        input  tlast,
        input  tuser
    );

endinterface

// File: udp_port_filter.sv
`include "udp_echo_params.svh"

module udp_port_filter
    import udp_echo_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,

    // Parsed UDP header from the stack
    input  logic                   rx_hdr_valid,
    output logic                   rx_hdr_ready,
    input  logic [31:0]            rx_source_ip,
    input  logic [15:0]            rx_source_port,
    input  logic [15:0]            rx_dest_port,
    input  logic [15:0]            rx_length,

    // Received payload
    input  logic [`UDP_DATA_W-1:0] rx_payload_tdata,
    input  logic [`UDP_KEEP_W-1:0] rx_payload_tkeep,
    input  logic                   rx_payload_tvalid,
    output logic                   rx_payload_tready,
    input  logic                   rx_payload_tlast,
    input  logic                   rx_payload_tuser,

    // Reply header towards the reply stage
    output logic                   reply_valid,
    output reply_hdr_t             reply_hdr,
    input  logic                   reply_ready,

    // Payload towards the FIFO
    udp_stream_if.source           fifo_in
);

    filter_state_t state_q;
    filter_state_t state_d;
    logic          hdr_match;
    logic          hdr_accept;
    logic          beat_last;

    assign hdr_match = (rx_dest_port == `UDP_ECHO_PORT);

    // Only one header per frame, taken between frames
    // A matching header has to wait for room in the reply register
    assign rx_hdr_ready = (state_q == FILTER_IDLE) && (!hdr_match || reply_ready);
    assign reply_valid  = (state_q == FILTER_IDLE) && rx_hdr_valid && hdr_match;
    assign hdr_accept   = rx_hdr_valid && rx_hdr_ready;

    // Swap ports and send back to the sender
    always_comb begin
        reply_hdr.dest_ip     = rx_source_ip;
        reply_hdr.source_port = rx_dest_port;
        reply_hdr.dest_port   = rx_source_port;
        reply_hdr.length      = rx_length;
    end

    // Payload goes to the FIFO when echoing, otherwise it is drained
    assign fifo_in.tdata  = rx_payload_tdata;
    assign fifo_in.tkeep  = rx_payload_tkeep;
    assign fifo_in.tlast  = rx_payload_tlast;
    assign fifo_in.tuser  = rx_payload_tuser;
    assign fifo_in.tvalid = (state_q == FILTER_ECHO) && rx_payload_tvalid;

    always_comb begin
        case (state_q)
            FILTER_ECHO: rx_payload_tready = fifo_in.tready;
            FILTER_DROP: rx_payload_tready = 1'b1;
            default:     rx_payload_tready = 1'b0;
        endcase
    end

    assign beat_last = rx_payload_tvalid && rx_payload_tready && rx_payload_tlast;

    always_comb begin
        state_d = state_q;
        case (state_q)
            FILTER_IDLE: begin
                if (hdr_accept) begin
                    state_d = hdr_match ? FILTER_ECHO : FILTER_DROP;
                end
            end
            FILTER_ECHO, FILTER_DROP: begin
                // Frame ends on the handshake of its last beat
                if (beat_last) begin
                    state_d = FILTER_IDLE;
                end
            end
            default: state_d = FILTER_IDLE;
        endcase
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            state_q <= FILTER_IDLE;
        end else begin
            state_q <= state_d;
        end
    end

    // A stalled rx beat is held by the stack until it is taken
    a_rx_beat_held: assert property (
        @(posedge clk) disable iff (rst)
        rx_payload_tvalid && !rx_payload_tready |=>
            rx_payload_tvalid &&
            $stable({rx_payload_tdata, rx_payload_tkeep, rx_payload_tlast, rx_payload_tuser})
    );

endmodule

// File: udp_payload_fifo.sv
`include "udp_echo_params.svh"

module udp_payload_fifo #(
    parameter int ADDR_W = `UDP_FIFO_ADDR_W
) (
    input  logic         clk,
    input  logic         rst,
    udp_stream_if.sink   fifo_in,
    udp_stream_if.source fifo_out
);

    localparam int DEPTH   = 1 << ADDR_W;
    localparam int ENTRY_W = `UDP_DATA_W + `UDP_KEEP_W + 2;

    // Each entry holds last, user, keep and data
    logic [ENTRY_W-1:0] mem [DEPTH];
    logic [ENTRY_W-1:0] head;

    logic [ADDR_W-1:0]  wr_ptr_q;
    logic [ADDR_W-1:0]  rd_ptr_q;
    logic [ADDR_W:0]    count_q;

    logic full;
    logic empty;
    logic wr_en;
    logic rd_en;

    assign full  = (count_q == (ADDR_W + 1)'(DEPTH));
    assign empty = (count_q == '0);

    assign fifo_in.tready  = !full;
    assign fifo_out.tvalid = !empty;

    assign wr_en = fifo_in.tvalid && fifo_in.tready;
    assign rd_en = fifo_out.tvalid && fifo_out.tready;

    always_ff @(posedge clk) begin
        if (wr_en) begin
            mem[wr_ptr_q] <= {fifo_in.tlast, fifo_in.tuser, fifo_in.tkeep, fifo_in.tdata};
        end
    end

    // Head entry falls through to the output
    assign head = mem[rd_ptr_q];

    assign fifo_out.tdata = head[`UDP_DATA_W-1:0];
    assign fifo_out.tkeep = head[`UDP_DATA_W +: `UDP_KEEP_W];
    assign fifo_out.tuser = head[ENTRY_W-2];
    assign fifo_out.tlast = head[ENTRY_W-1];

    always_ff @(posedge clk) begin
        if (rst) begin
            wr_ptr_q <= '0;
            rd_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            if (wr_en) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (rd_en) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({wr_en, rd_en})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    // Pointer distance matches the occupancy, which never passes the depth
    a_occupancy_consistent: assert property (
        @(posedge clk) disable iff (rst)
        count_q <= (ADDR_W + 1)'(DEPTH) &&
            ADDR_W'(wr_ptr_q - rd_ptr_q) == count_q[ADDR_W-1:0]
    );

endmodule

// File: udp_reply_tx.sv
`include "udp_echo_params.svh"

module udp_reply_tx
    import udp_echo_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,

    // Reply header from the filter
    input  logic                   reply_valid,
    input  reply_hdr_t             reply_hdr,
    output logic                   reply_ready,

    // Echoed payload from the FIFO
    udp_stream_if.sink             fifo_out,

    // Reply header to the stack
    output logic                   tx_hdr_valid,
    input  logic                   tx_hdr_ready,
    output logic [31:0]            tx_dest_ip,
    output logic [15:0]            tx_source_port,
    output logic [15:0]            tx_dest_port,
    output logic [15:0]            tx_length,

    // Reply payload to the stack
    output logic [`UDP_DATA_W-1:0] tx_payload_tdata,
    output logic [`UDP_KEEP_W-1:0] tx_payload_tkeep,
    output logic                   tx_payload_tvalid,
    input  logic                   tx_payload_tready,
    output logic                   tx_payload_tlast,
    output logic                   tx_payload_tuser,

    output logic [`UDP_LED_W-1:0]  led
);

    reply_hdr_t                 hdr_q;
    logic                       hdr_valid_q;
    logic                       first_beat_q;
    logic [`UDP_LED_W-1:0]      led_q;
    logic                       beat_done;

    // Single entry header register
    assign reply_ready = !hdr_valid_q;

    always_ff @(posedge clk) begin
        if (reply_valid && reply_ready) begin
            hdr_q <= reply_hdr;
        end
    end

    always_ff @(posedge clk) begin
        if (rst) begin
            hdr_valid_q <= 1'b0;
        end else if (reply_valid && reply_ready) begin
            hdr_valid_q <= 1'b1;
        end else if (tx_hdr_ready) begin
            hdr_valid_q <= 1'b0;
        end
    end

    assign tx_hdr_valid   = hdr_valid_q;
    assign tx_dest_ip     = hdr_q.dest_ip;
    assign tx_source_port = hdr_q.source_port;
    assign tx_dest_port   = hdr_q.dest_port;
    assign tx_length      = hdr_q.length;

    assign tx_payload_tdata  = fifo_out.tdata;
    assign tx_payload_tkeep  = fifo_out.tkeep;
    assign tx_payload_tvalid = fifo_out.tvalid;
    assign tx_payload_tlast  = fifo_out.tlast;
    assign tx_payload_tuser  = fifo_out.tuser;
    assign fifo_out.tready   = tx_payload_tready;

    assign beat_done = tx_payload_tvalid && tx_payload_tready;

    // Frame start follows reset or a tlast beat, so back-to-back frames count too
    always_ff @(posedge clk) begin
        if (rst) begin
            first_beat_q <= 1'b1;
            led_q        <= '0;
        end else if (beat_done) begin
            first_beat_q <= tx_payload_tlast;
            if (first_beat_q) begin
                led_q <= tx_payload_tdata[`UDP_LED_W-1:0];
            end
        end
    end

    assign led = led_q;

    // Echoed beat from the FIFO stays put while the stack stalls it
    a_payload_held: assert property (
        @(posedge clk) disable iff (rst)
        fifo_out.tvalid && !fifo_out.tready |=>
            fifo_out.tvalid &&
            $stable({fifo_out.tdata, fifo_out.tkeep, fifo_out.tlast, fifo_out.tuser})
    );

endmodule

// File: udp_echo_core.sv
`include "udp_echo_params.svh"

module udp_echo_core
    import udp_echo_pkg::*;
(
    input  logic                   clk,
    input  logic                   rst,

    // Received UDP header
    input  logic                   rx_hdr_valid,
    output logic                   rx_hdr_ready,
    input  logic [31:0]            rx_source_ip,
    input  logic [15:0]            rx_source_port,
    input  logic [15:0]            rx_dest_port,
    input  logic [15:0]            rx_length,

    // Received UDP payload
    input  logic [`UDP_DATA_W-1:0] rx_payload_tdata,
    input  logic [`UDP_KEEP_W-1:0] rx_payload_tkeep,
    input  logic                   rx_payload_tvalid,
    output logic                   rx_payload_tready,
    input  logic                   rx_payload_tlast,
    input  logic                   rx_payload_tuser,

    // Reply UDP header
    output logic                   tx_hdr_valid,
    input  logic                   tx_hdr_ready,
    output logic [31:0]            tx_dest_ip,
    output logic [15:0]            tx_source_port,
    output logic [15:0]            tx_dest_port,
    output logic [15:0]            tx_length,

    // Reply UDP payload
    output logic [`UDP_DATA_W-1:0] tx_payload_tdata,
    output logic [`UDP_KEEP_W-1:0] tx_payload_tkeep,
    output logic                   tx_payload_tvalid,
    input  logic                   tx_payload_tready,
    output logic                   tx_payload_tlast,
    output logic                   tx_payload_tuser,

    output logic [`UDP_LED_W-1:0]  led
);

    logic       reply_valid;
    logic       reply_ready;
    reply_hdr_t reply_hdr;

    udp_stream_if fifo_in ();
    udp_stream_if fifo_out ();

    udp_port_filter i_filter (
        .clk               (clk),
        .rst               (rst),
        .rx_hdr_valid      (rx_hdr_valid),
        .rx_hdr_ready      (rx_hdr_ready),
        .rx_source_ip      (rx_source_ip),
        .rx_source_port    (rx_source_port),
        .rx_dest_port      (rx_dest_port),
        .rx_length         (rx_length),
        .rx_payload_tdata  (rx_payload_tdata),
        .rx_payload_tkeep  (rx_payload_tkeep),
        .rx_payload_tvalid (rx_payload_tvalid),
        .rx_payload_tready (rx_payload_tready),
        .rx_payload_tlast  (rx_payload_tlast),
        .rx_payload_tuser  (rx_payload_tuser),
        .reply_valid       (reply_valid),
        .reply_hdr         (reply_hdr),
        .reply_ready       (reply_ready),
        .fifo_in           (fifo_in.source)
    );

    // Echo payload buffer
    udp_payload_fifo #(
        .ADDR_W (`UDP_FIFO_ADDR_W)
    ) i_fifo (
        .clk      (clk),
        .rst      (rst),
        .fifo_in  (fifo_in.sink),
        .fifo_out (fifo_out.source)
    );

    udp_reply_tx i_reply (
        .clk               (clk),
        .rst               (rst),
        .reply_valid       (reply_valid),
        .reply_hdr         (reply_hdr),
        .reply_ready       (reply_ready),
        .fifo_out          (fifo_out.sink),
        .tx_hdr_valid      (tx_hdr_valid),
        .tx_hdr_ready      (tx_hdr_ready),
        .tx_dest_ip        (tx_dest_ip),
        .tx_source_port    (tx_source_port),
        .tx_dest_port      (tx_dest_port),
        .tx_length         (tx_length),
        .tx_payload_tdata  (tx_payload_tdata),
        .tx_payload_tkeep  (tx_payload_tkeep),
        .tx_payload_tvalid (tx_payload_tvalid),
        .tx_payload_tready (tx_payload_tready),
        .tx_payload_tlast  (tx_payload_tlast),
        .tx_payload_tuser  (tx_payload_tuser),
        .led               (led)
    );

endmodule

// File: tb_udp_echo_core.sv
`include "udp_echo_params.svh"

module tb_udp_echo_core;

    localparam int CLK_PERIOD = 8;
    localparam int N_FRAMES   = 46;
    // Every frame carries at most six beats
    localparam int MAX_BEATS       = N_FRAMES * 6;
    localparam int WATCHDOG_CYCLES = MAX_BEATS * 50 + 2000;
    localparam int ENTRY_W         = `UDP_DATA_W + `UDP_KEEP_W + 2;

    logic                   clk;
    logic                   rst;
    logic                   rx_hdr_valid;
    logic                   rx_hdr_ready;
    logic [31:0]            rx_source_ip;
    logic [15:0]            rx_source_port;
    logic [15:0]            rx_dest_port;
    logic [15:0]            rx_length;
    logic [`UDP_DATA_W-1:0] rx_payload_tdata;
    logic [`UDP_KEEP_W-1:0] rx_payload_tkeep;
    logic                   rx_payload_tvalid;
    logic                   rx_payload_tready;
    logic                   rx_payload_tlast;
    logic                   rx_payload_tuser;
    logic                   tx_hdr_valid;
    logic                   tx_hdr_ready;
    logic [31:0]            tx_dest_ip;
    logic [15:0]            tx_source_port;
    logic [15:0]            tx_dest_port;
    logic [15:0]            tx_length;
    logic [`UDP_DATA_W-1:0] tx_payload_tdata;
    logic [`UDP_KEEP_W-1:0] tx_payload_tkeep;
    logic                   tx_payload_tvalid;
    logic                   tx_payload_tready;
    logic                   tx_payload_tlast;
    logic                   tx_payload_tuser;
    logic [`UDP_LED_W-1:0]  led;

    // Expected replies, pushed by the driver for echoed frames only
    logic [79:0]            exp_hdr[$];
    logic [ENTRY_W-1:0]     exp_beat[$];

    logic [15:0]            lfsr = 16'd34742;
    logic                   stall_en;
    logic                   rx_hdr_fire;
    logic                   rx_beat_fire;
    logic                   out_first;
    logic [`UDP_LED_W-1:0]  exp_led;
    logic [`UDP_LED_W-1:0]  last_led_byte;
    int                     checks;
    int                     errors;
    int                     tests;
    int                     test_errors;

    udp_echo_core i_dut (.*);

    initial begin
        clk = 1'b0;
        forever #(CLK_PERIOD / 2) clk = ~clk;
    end

    // Taps 16, 14, 13, 11
    function automatic logic [31:0] rand_bits(input int n);
        logic [31:0] value;
        logic        fb;
        value = '0;
        for (int i = 0; i < n; i++) begin
            fb    = lfsr[15] ^ lfsr[13] ^ lfsr[12] ^ lfsr[10];
            lfsr  = {lfsr[14:0], fb};
            value = {value[30:0], fb};
        end
        return value;
    endfunction

    task automatic report_mismatch(input string msg);
        errors++;
        $display("mismatch at %0t: %s", $time, msg);
    endtask

    task automatic report_failure(input string msg);
        errors++;
        $display("error at %0t: %s", $time, msg);
    endtask

    // Input side handshakes, seen by the driver at the next falling edge
    always @(posedge clk) begin
        rx_hdr_fire  <= rx_hdr_valid && rx_hdr_ready;
        rx_beat_fire <= rx_payload_tvalid && rx_payload_tready;
    end

    always @(negedge clk) begin
        if (stall_en) begin
            tx_hdr_ready      = (rand_bits(2) != 0);
            tx_payload_tready = (rand_bits(2) != 0);
        end else begin
            tx_hdr_ready      = 1'b1;
            tx_payload_tready = 1'b1;
        end
    end

    always @(posedge clk) begin
        logic [79:0]        got_hdr;
        logic [ENTRY_W-1:0] got_beat;
        logic [79:0]        want_hdr;
        logic [ENTRY_W-1:0] want_beat;
        got_hdr  = {tx_dest_ip, tx_source_port, tx_dest_port, tx_length};
        got_beat = {tx_payload_tlast, tx_payload_tuser, tx_payload_tkeep, tx_payload_tdata};
        if (rst) begin
            out_first <= 1'b1;
        end
        if (!rst && tx_hdr_valid && tx_hdr_ready) begin
            if (exp_hdr.size() == 0) begin
                report_failure("tx header appeared with no echoed frame pending");
            end else begin
                want_hdr = exp_hdr.pop_front();
                checks++;
                assert (got_hdr == want_hdr)
                    else report_mismatch($sformatf("tx header %h, expected %h",
                                                   got_hdr, want_hdr));
            end
        end
        if (!rst && tx_payload_tvalid && tx_payload_tready) begin
            if (exp_beat.size() == 0) begin
                report_failure("tx payload beat appeared with no echoed beat pending");
            end else begin
                want_beat = exp_beat.pop_front();
                // Next frame starts after the expected tlast beat
                if (out_first) begin
                    exp_led <= want_beat[`UDP_LED_W-1:0];
                end
                out_first <= want_beat[ENTRY_W-1];
                checks++;
                assert (got_beat == want_beat)
                    else report_mismatch($sformatf("tx beat %h, expected %h",
                                                   got_beat, want_beat));
            end
        end
    end

    a_led_first_byte: assert property (
        @(posedge clk) disable iff (rst)
        tx_payload_tvalid && tx_payload_tready && out_first |=> led == exp_led
    ) else report_mismatch("led does not show the low byte of the first beat");

    a_hdr_hold: assert property (
        @(posedge clk) disable iff (rst)
        tx_hdr_valid && !tx_hdr_ready |=>
            tx_hdr_valid && $stable({tx_dest_ip, tx_source_port, tx_dest_port, tx_length})
    ) else report_mismatch("tx header changed or dropped while stalled");

    task automatic send_frame(input logic match);
        logic [31:0]            src_ip;
        logic [15:0]            src_port;
        logic [15:0]            dst_port;
        logic [15:0]            udp_len;
        logic [`UDP_DATA_W-1:0] data;
        logic [`UDP_KEEP_W-1:0] keep;
        logic                   user;
        logic                   last;
        int                     beats;
        beats    = int'(rand_bits(3) % 6) + 1;
        src_ip   = rand_bits(32);
        src_port = 16'(rand_bits(16));
        dst_port = match ? `UDP_ECHO_PORT : 16'(rand_bits(16));
        if (!match && dst_port == `UDP_ECHO_PORT) begin
            dst_port = dst_port + 16'd1;
        end
        udp_len = 16'(8 + beats * 8);
        // Reply returns to the sender with the ports swapped
        if (match) begin
            exp_hdr.push_back({src_ip, dst_port, src_port, udp_len});
        end
        rx_hdr_valid   = 1'b1;
        rx_source_ip   = src_ip;
        rx_source_port = src_port;
        rx_dest_port   = dst_port;
        rx_length      = udp_len;
        @(negedge clk);
        while (!rx_hdr_fire) @(negedge clk);
        rx_hdr_valid = 1'b0;
        for (int i = 0; i < beats; i++) begin
            last = (i == beats - 1);
            data = {rand_bits(32), rand_bits(32)};
            keep = last ? (8'hff >> rand_bits(3)) : 8'hff;
            user = last ? 1'(rand_bits(1)) : 1'b0;
            if (match) begin
                exp_beat.push_back({last, user, keep, data});
                if (i == 0) begin
                    last_led_byte = data[`UDP_LED_W-1:0];
                end
            end
            rx_payload_tdata  = data;
            rx_payload_tkeep  = keep;
            rx_payload_tlast  = last;
            rx_payload_tuser  = user;
            rx_payload_tvalid = 1'b1;
            @(negedge clk);
            while (!rx_beat_fire) @(negedge clk);
        end
        rx_payload_tvalid = 1'b0;
    endtask

    // Replies drained, then a short quiet spell to catch stray outputs
    task automatic wait_drain();
        while (exp_hdr.size() != 0 || exp_beat.size() != 0) @(negedge clk);
        repeat (4) @(negedge clk);
        checks++;
        assert (!tx_hdr_valid && !tx_payload_tvalid)
            else report_failure("tx output still busy after all expected replies");
    endtask

    task automatic end_test(input string name);
        tests++;
        $display("test %s finished with %0d errors", name, errors - test_errors);
        test_errors = errors;
    endtask

    initial begin
        #(WATCHDOG_CYCLES * CLK_PERIOD);
        $display("timeout: run did not finish within %0d cycles", WATCHDOG_CYCLES);
        $display("TEST RESULT: FAIL");
        $finish;
    end

    initial begin
        rst               = 1'b1;
        stall_en          = 1'b0;
        rx_hdr_valid      = 1'b0;
        rx_source_ip      = '0;
        rx_source_port    = '0;
        rx_dest_port      = '0;
        rx_length         = '0;
        rx_payload_tdata  = '0;
        rx_payload_tkeep  = '0;
        rx_payload_tvalid = 1'b0;
        rx_payload_tlast  = 1'b0;
        rx_payload_tuser  = 1'b0;
        tx_hdr_ready      = 1'b1;
        tx_payload_tready = 1'b1;
        checks            = 0;
        errors            = 0;
        tests             = 0;
        test_errors       = 0;
        repeat (8) @(negedge clk);
        rst = 1'b0;
        @(negedge clk);

        // Idle filter takes a non-matching header but no payload
        checks++;
        assert (!tx_hdr_valid && !tx_payload_tvalid && led == '0 &&
                rx_hdr_ready && !rx_payload_tready)
            else report_mismatch("outputs not idle after reset");
        end_test("reset");

        send_frame(1'b1);
        wait_drain();
        end_test("echo");

        send_frame(1'b0);
        wait_drain();
        end_test("drop");

        stall_en = 1'b1;
        repeat (20) send_frame(1'b1);
        wait_drain();
        stall_en = 1'b0;
        end_test("backpressure");

        repeat (4) send_frame(1'b1);
        wait_drain();
        checks++;
        assert (led == last_led_byte)
            else report_mismatch($sformatf("led %h, expected %h", led, last_led_byte));
        end_test("led");

        stall_en = 1'b1;
        repeat (20) send_frame(1'(rand_bits(1)));
        wait_drain();
        stall_en = 1'b0;
        end_test("mixed");

        $display("tests %0d, checks %0d, errors %0d", tests, checks, errors);
        if (errors == 0) begin
            $display("TEST RESULT: PASS");
        end else begin
            $display("TEST RESULT: FAIL");
        end
        $finish;
    end

endmodule

// File: udp_echo_core.f
+incdir+.
udp_echo_pkg.sv
udp_stream_if.sv
udp_port_filter.sv
udp_payload_fifo.sv
udp_reply_tx.sv
udp_echo_core.sv
tb_udp_echo_core.sv

// File: Bender.yml
package:
  name: udp_echo_core

sources:
  - include_dirs:
      - .
    files:
      - udp_echo_pkg.sv
      - udp_stream_if.sv
      - udp_port_filter.sv
      - udp_payload_fifo.sv
      - udp_reply_tx.sv
      - udp_echo_core.sv
  - target: test
    include_dirs:
      - .
    files:
      - tb_udp_echo_core.sv
